//--- verilog/decode_pkg.sv
package decode_pkg;

    localparam int INST_W = 32;
    localparam int IMM_W = 20;
    localparam int REG_IDX_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    // sub and arithmetic shift
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHIFT,
        IMM_CSR
    } imm_fmt_e;

    typedef enum logic [3:0] {
        CLS_INT_MATH,
        CLS_IMM_MATH,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_MULDIV,
        CLS_CSR,
        CLS_UNKNOWN
    } inst_class_e;

    // one code space for alu, bru and mdu
    typedef enum logic [5:0] {
        MOP_NONE = 6'd0,
        // alu
        MOP_LUI, MOP_ADD, MOP_SUB, MOP_ADDW, MOP_SUBW,
        MOP_SLL, MOP_SRL, MOP_SRA, MOP_SLLW, MOP_SRLW, MOP_SRAW,
        MOP_XOR, MOP_OR, MOP_AND, MOP_SLT, MOP_SLTU,
        // bru
        MOP_AUIPC, MOP_JAL, MOP_JALR,
        MOP_BEQ, MOP_BNE, MOP_BLT, MOP_BGE, MOP_BLTU, MOP_BGEU,
        // mdu codes stay contiguous
        MOP_MUL, MOP_MULW, MOP_MULH, MOP_MULHU, MOP_MULHSU,
        MOP_DIV, MOP_DIVW, MOP_DIVU, MOP_DIVUW,
        MOP_REM, MOP_REMW, MOP_REMU, MOP_REMUW
    } micop_e;

    typedef enum logic [1:0] {
        DQ_INT_BLOCK,
        DQ_MEM_BLOCK,
        DQ_UNKNOWN_BLOCK
    } disp_que_e;

    typedef enum logic [1:0] {
        IQ_ALU,
        IQ_MDU,
        IQ_BRU
    } issue_que_e;

    // indices are zero wherever the matching enable is clear
    typedef struct packed {
        logic                 rd_wen;
        logic [REG_IDX_W-1:0] rd_idx;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic                 rs1_ren;
        logic                 rs2_ren;
        logic                 is_mv;
    } reg_fields_t;

    typedef struct packed {
        reg_fields_t      regs;
        logic [IMM_W-1:0] imm20;
        logic             use_imm;
        micop_e           micop;
        disp_que_e        disp_que;
        issue_que_e       issue_que;
        logic             is_store;
    } dec_info_t;

endpackage

//--- verilog/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl import decode_pkg::*; (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_valid,
    input  logic [INST_W-1:0] i_inst,
    output inst_class_e       o_class,
    output imm_fmt_e          o_imm_fmt,
    input  logic [IMM_W-1:0]  i_imm,
    input  reg_fields_t       i_reg_fields,
    input  micop_e            i_micop,
    input  disp_que_e         i_disp_que,
    input  issue_que_e        i_issue_que,
    output logic              o_valid,
    output dec_info_t         o_decinfo,
    output logic              o_unknown_inst
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       shift_op;
    dec_info_t  dec_next;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign shift_op = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        o_class = CLS_UNKNOWN;
        // anything without 2'b11 is compressed
        if (i_inst[1:0] == 2'b11) begin
            case (opcode)
                OPC_OP: begin
                    if (funct7 == FUNCT7_MULDIV) begin
                        o_class = CLS_MULDIV;
                    end else if (funct7 == FUNCT7_BASE) begin
                        o_class = CLS_INT_MATH;
                    end else if (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                        o_class = CLS_INT_MATH;
                    end
                end
                OPC_OP_32: begin
                    if (funct7 == FUNCT7_MULDIV && (funct3 == 3'b000 || funct3[2])) begin
                        o_class = CLS_MULDIV;
                    end else if (funct7 == FUNCT7_BASE && (funct3 == 3'b000 || shift_op)) begin
                        o_class = CLS_INT_MATH;
                    end else if (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                        o_class = CLS_INT_MATH;
                    end
                end
                OPC_OP_IMM: begin
                    // rv64 shifts carry a 6-bit shamt
                    if (funct3 == 3'b001) begin
                        if (i_inst[31:26] == 6'b000000) begin
                            o_class = CLS_IMM_MATH;
                        end
                    end else if (funct3 == 3'b101) begin
                        if (i_inst[31:26] == 6'b000000 || i_inst[31:26] == 6'b010000) begin
                            o_class = CLS_IMM_MATH;
                        end
                    end else begin
                        o_class = CLS_IMM_MATH;
                    end
                end
                OPC_OP_IMM_32: begin
                    if (funct3 == 3'b000) begin
                        o_class = CLS_IMM_MATH;
                    end else if (funct3 == 3'b001 && funct7 == FUNCT7_BASE) begin
                        o_class = CLS_IMM_MATH;
                    end else if (funct3 == 3'b101 && (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT)) begin
                        o_class = CLS_IMM_MATH;
                    end
                end
                OPC_LUI:    o_class = CLS_LUI;
                OPC_AUIPC:  o_class = CLS_AUIPC;
                OPC_JAL:    o_class = CLS_JAL;
                OPC_JALR:   o_class = (funct3 == 3'b000) ? CLS_JALR : CLS_UNKNOWN;
                OPC_BRANCH: o_class = (funct3[2:1] != 2'b01) ? CLS_BRANCH : CLS_UNKNOWN;
                OPC_LOAD:   o_class = (funct3 != 3'b111) ? CLS_LOAD : CLS_UNKNOWN;
                OPC_STORE:  o_class = (!funct3[2]) ? CLS_STORE : CLS_UNKNOWN;
                // funct3 of zero holds ecall, ebreak, mret and friends
                OPC_SYSTEM: o_class = (funct3 != 3'b000) ? CLS_CSR : CLS_UNKNOWN;
                default:    o_class = CLS_UNKNOWN;
            endcase
        end
    end

    always_comb begin
        case (o_class)
            CLS_IMM_MATH: o_imm_fmt = shift_op ? IMM_SHIFT : IMM_I;
            CLS_LOAD,
            CLS_JALR:     o_imm_fmt = IMM_I;
            CLS_STORE:    o_imm_fmt = IMM_S;
            CLS_BRANCH:   o_imm_fmt = IMM_B;
            CLS_LUI,
            CLS_AUIPC:    o_imm_fmt = IMM_U;
            CLS_JAL:      o_imm_fmt = IMM_J;
            CLS_CSR:      o_imm_fmt = IMM_CSR;
            default:      o_imm_fmt = IMM_NONE;
        endcase
    end

    always_comb begin
        dec_next.regs = i_reg_fields;
        dec_next.imm20 = i_imm;
        dec_next.use_imm = (o_imm_fmt != IMM_NONE);
        dec_next.micop = i_micop;
        dec_next.disp_que = i_disp_que;
        dec_next.issue_que = i_issue_que;
        dec_next.is_store = (o_class == CLS_STORE);
    end

    // record holds while no instruction is presented
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_decinfo <= '0;
            o_unknown_inst <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_decinfo <= dec_next;
                o_unknown_inst <= (o_class == CLS_UNKNOWN);
            end
        end
    end

    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !$isunknown(o_valid));

    a_unknown_no_op: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_unknown_inst |-> (o_decinfo.micop == MOP_NONE));

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  logic [INST_W-1:0] i_inst,
    input  imm_fmt_e          i_imm_fmt,
    output logic [IMM_W-1:0]  o_imm
);

    logic [IMM_W-1:0] imm_i;
    logic [IMM_W-1:0] imm_s;
    logic [IMM_W-1:0] imm_b;
    logic [IMM_W-1:0] imm_u;
    logic [IMM_W-1:0] imm_j;
    logic [IMM_W-1:0] imm_shift;
    logic [IMM_W-1:0] imm_csr;

    assign imm_i = {{8{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{7{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    // upper 20 bits get shifted into place downstream
    assign imm_u = i_inst[31:12];
    assign imm_j = {i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign imm_shift = {15'd0, i_inst[24:20]};
    // csr index over the zimm / rs1 field
    assign imm_csr = {3'd0, i_inst[31:20], i_inst[19:15]};

    always_comb begin
        case (i_imm_fmt)
            IMM_I:     o_imm = imm_i;
            IMM_S:     o_imm = imm_s;
            IMM_B:     o_imm = imm_b;
            IMM_U:     o_imm = imm_u;
            IMM_J:     o_imm = imm_j;
            IMM_SHIFT: o_imm = imm_shift;
            IMM_CSR:   o_imm = imm_csr;
            default:   o_imm = '0;
        endcase
    end

endmodule

//--- verilog/reg_field_unit.sv
`timescale 1ns/1ps

module reg_field_unit import decode_pkg::*; (
    input  logic [INST_W-1:0] i_inst,
    input  inst_class_e       i_class,
    output reg_fields_t       o_reg_fields
);

    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic                 rd_used;
    logic                 rs1_used;
    logic                 rs2_used;
    logic                 mv_addi;
    logic                 mv_add;

    assign rd = i_inst[11:7];
    assign rs1 = i_inst[19:15];
    assign rs2 = i_inst[24:20];

    assign rd_used = i_class inside {CLS_INT_MATH, CLS_IMM_MATH, CLS_LUI, CLS_AUIPC,
                                     CLS_JAL, CLS_JALR, CLS_LOAD, CLS_CSR, CLS_MULDIV};
    // immediate csr forms reuse rs1 as zimm
    assign rs1_used = (i_class inside {CLS_INT_MATH, CLS_IMM_MATH, CLS_JALR, CLS_BRANCH,
                                       CLS_LOAD, CLS_STORE, CLS_MULDIV})
                      || (i_class == CLS_CSR && !i_inst[14]);
    assign rs2_used = i_class inside {CLS_INT_MATH, CLS_BRANCH, CLS_STORE, CLS_MULDIV};

    // addi rd, rs1, 0 and add rd, rs1, x0
    assign mv_addi = (i_class == CLS_IMM_MATH) && (i_inst[6:0] == OPC_OP_IMM)
                     && (i_inst[14:12] == 3'b000) && (i_inst[31:20] == 12'd0);
    assign mv_add = (i_class == CLS_INT_MATH) && (i_inst[6:0] == OPC_OP)
                    && (i_inst[14:12] == 3'b000) && (i_inst[31:25] == FUNCT7_BASE)
                    && (rs2 == '0);

    always_comb begin
        o_reg_fields.rd_wen = rd_used && (rd != '0);
        o_reg_fields.rs1_ren = rs1_used && (rs1 != '0);
        o_reg_fields.rs2_ren = rs2_used && (rs2 != '0);
        o_reg_fields.rd_idx = o_reg_fields.rd_wen ? rd : '0;
        o_reg_fields.rs1_idx = o_reg_fields.rs1_ren ? rs1 : '0;
        o_reg_fields.rs2_idx = o_reg_fields.rs2_ren ? rs2 : '0;
        o_reg_fields.is_mv = mv_addi || mv_add;
    end

endmodule

//--- verilog/micop_encoder.sv
`timescale 1ns/1ps

module micop_encoder import decode_pkg::*; (
    input  logic [INST_W-1:0] i_inst,
    input  inst_class_e       i_class,
    output micop_e            o_micop,
    output disp_que_e         o_disp_que,
    output issue_que_e        o_issue_que
);

    logic [2:0] funct3;
    logic       word_op;
    logic       alt;
    logic       is_sub;

    assign funct3 = i_inst[14:12];
    assign word_op = (i_inst[6:0] == OPC_OP_32) || (i_inst[6:0] == OPC_OP_IMM_32);
    // bit 30 picks sub and sra once the class check has vetted funct7
    assign alt = i_inst[30];
    assign is_sub = alt && (i_class == CLS_INT_MATH);

    always_comb begin
        o_micop = MOP_NONE;
        case (i_class)
            CLS_INT_MATH,
            CLS_IMM_MATH: begin
                case (funct3)
                    3'b000:  o_micop = is_sub ? (word_op ? MOP_SUBW : MOP_SUB)
                                              : (word_op ? MOP_ADDW : MOP_ADD);
                    3'b001:  o_micop = word_op ? MOP_SLLW : MOP_SLL;
                    3'b010:  o_micop = MOP_SLT;
                    3'b011:  o_micop = MOP_SLTU;
                    3'b100:  o_micop = MOP_XOR;
                    3'b101:  o_micop = alt ? (word_op ? MOP_SRAW : MOP_SRA)
                                           : (word_op ? MOP_SRLW : MOP_SRL);
                    3'b110:  o_micop = MOP_OR;
                    default: o_micop = MOP_AND;
                endcase
            end
            CLS_LUI:   o_micop = MOP_LUI;
            CLS_AUIPC: o_micop = MOP_AUIPC;
            CLS_JAL:   o_micop = MOP_JAL;
            CLS_JALR:  o_micop = MOP_JALR;
            CLS_BRANCH: begin
                case (funct3)
                    3'b000:  o_micop = MOP_BEQ;
                    3'b001:  o_micop = MOP_BNE;
                    3'b100:  o_micop = MOP_BLT;
                    3'b101:  o_micop = MOP_BGE;
                    3'b110:  o_micop = MOP_BLTU;
                    default: o_micop = MOP_BGEU;
                endcase
            end
            CLS_MULDIV: begin
                case (funct3)
                    3'b000:  o_micop = word_op ? MOP_MULW : MOP_MUL;
                    3'b001:  o_micop = MOP_MULH;
                    3'b010:  o_micop = MOP_MULHSU;
                    3'b011:  o_micop = MOP_MULHU;
                    3'b100:  o_micop = word_op ? MOP_DIVW : MOP_DIV;
                    3'b101:  o_micop = word_op ? MOP_DIVUW : MOP_DIVU;
                    3'b110:  o_micop = word_op ? MOP_REMW : MOP_REM;
                    default: o_micop = word_op ? MOP_REMUW : MOP_REMU;
                endcase
            end
            default:   o_micop = MOP_NONE;
        endcase
    end

    assign o_disp_que = (i_class == CLS_LOAD || i_class == CLS_STORE) ? DQ_MEM_BLOCK :
                        (i_class == CLS_UNKNOWN)                      ? DQ_UNKNOWN_BLOCK :
                                                                        DQ_INT_BLOCK;

    assign o_issue_que = (i_class inside {CLS_INT_MATH, CLS_IMM_MATH, CLS_LUI}) ? IQ_ALU :
                         (i_class == CLS_MULDIV)                                ? IQ_MDU :
                                                                                  IQ_BRU;

    // an mdu code needs the m-extension funct7
    always_comb begin
        a_muldiv_op: assert final (!(o_micop inside {[MOP_MUL:MOP_REMUW]})
                                   || i_inst[31:25] == FUNCT7_MULDIV);
    end

endmodule

//--- verilog/decoder_top.sv
`timescale 1ns/1ps

module decoder_top import decode_pkg::*; (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_valid,
    input  logic [INST_W-1:0] i_inst,
    output logic              o_valid,
    output dec_info_t         o_decinfo,
    output logic              o_unknown_inst
);

    inst_class_e      inst_class;
    imm_fmt_e         imm_fmt;
    logic [IMM_W-1:0] imm;
    reg_fields_t      reg_fields;
    micop_e           micop;
    disp_que_e        disp_que;
    issue_que_e       issue_que;

    decode_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_valid        (i_valid),
        .i_inst         (i_inst),
        .o_class        (inst_class),
        .o_imm_fmt      (imm_fmt),
        .i_imm          (imm),
        .i_reg_fields   (reg_fields),
        .i_micop        (micop),
        .i_disp_que     (disp_que),
        .i_issue_que    (issue_que),
        .o_valid        (o_valid),
        .o_decinfo      (o_decinfo),
        .o_unknown_inst (o_unknown_inst)
    );

    imm_gen u_imm (
        .i_inst    (i_inst),
        .i_imm_fmt (imm_fmt),
        .o_imm     (imm)
    );

    reg_field_unit u_regs (
        .i_inst       (i_inst),
        .i_class      (inst_class),
        .o_reg_fields (reg_fields)
    );

    micop_encoder u_micop (
        .i_inst      (i_inst),
        .i_class     (inst_class),
        .o_micop     (micop),
        .o_disp_que  (disp_que),
        .o_issue_que (issue_que)
    );

endmodule

//--- testbench/tb_decoder.sv
`timescale 1ns/1ps

module tb_decoder import decode_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS = 2000;

    // entries are {mask, value} with masked bits forced and the rest random
    localparam logic [63:0] TMPL [32] = '{
        64'hFE00007F_00000033, 64'hFE00707F_40000033,  // op base, sub
        64'hFE00707F_40005033, 64'hFE00007F_02000033,  // sra, muldiv
        64'hFE00007F_0000003B, 64'hFE00707F_4000503B,  // op_32 base, sraw
        64'hFE00707F_4000003B, 64'hFE00407F_0200403B,  // subw, div/rem w
        64'hFE00707F_0200003B, 64'h0000007F_00000013,  // mulw, op_imm
        64'hFFF0707F_00000013, 64'hFC00707F_40005013,  // addi mv, srai
        64'hFC00707F_00001013, 64'h0000707F_0000001B,  // slli, addiw
        64'hFE00707F_0000101B, 64'hFE00707F_4000501B,  // slliw, sraiw
        64'h0000007F_00000037, 64'h0000007F_00000017,  // lui, auipc
        64'h0000007F_0000006F, 64'h0000707F_00000067,  // jal, jalr
        64'h0000007F_00000063, 64'h0000007F_00000003,  // branch, load
        64'h0000007F_00000023, 64'h0000007F_00000073,  // store, system
        64'hFFF0707F_00000033, 64'h00000001_00000000,  // add mv, compressed
        64'h0000007F_00000053, 64'h0000007F_00000007,  // op-fp, load-fp
        64'h0000007F_0000002F, 64'h0000007F_0000000F,  // amo, fence
        64'h0000707F_00000073, 64'h00000000_00000000   // ecall group, anything
    };

    localparam micop_e ALU_OP [8] = '{MOP_ADD, MOP_SLL, MOP_SLT, MOP_SLTU,
                                      MOP_XOR, MOP_SRL, MOP_OR, MOP_AND};
    localparam micop_e ALU_OP_W [8] = '{MOP_ADDW, MOP_SLLW, MOP_NONE, MOP_NONE,
                                        MOP_NONE, MOP_SRLW, MOP_NONE, MOP_NONE};
    localparam micop_e MDU_OP [8] = '{MOP_MUL, MOP_MULH, MOP_MULHSU, MOP_MULHU,
                                      MOP_DIV, MOP_DIVU, MOP_REM, MOP_REMU};
    localparam micop_e MDU_OP_W [8] = '{MOP_MULW, MOP_NONE, MOP_NONE, MOP_NONE,
                                        MOP_DIVW, MOP_DIVUW, MOP_REMW, MOP_REMUW};
    localparam micop_e BRU_OP [8] = '{MOP_BEQ, MOP_BNE, MOP_NONE, MOP_NONE,
                                      MOP_BLT, MOP_BGE, MOP_BLTU, MOP_BGEU};

    typedef struct packed {
        logic      unk;
        dec_info_t dec;
    } expect_t;

    logic              i_clk;
    logic              i_arst_n;
    logic              i_valid;
    logic [INST_W-1:0] i_inst;
    logic              o_valid;
    dec_info_t         o_decinfo;
    logic              o_unknown_inst;

    logic [15:0] lfsr;
    expect_t     exp_q [$];
    expect_t     last_out = '0;
    logic        exp_valid = 1'b0;
    int          num_checks = 0;
    int          num_errors = 0;

    decoder_top DUT (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_valid        (i_valid),
        .i_inst         (i_inst),
        .o_valid        (o_valid),
        .o_decinfo      (o_decinfo),
        .o_unknown_inst (o_unknown_inst)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] make_inst();
        logic [63:0] t;
        logic [31:0] r;
        t = TMPL[rand_bits(5)];
        r = rand_bits(32);
        return (r & ~t[63:32]) | (t[31:0] & t[63:32]);
    endfunction

    function automatic expect_t ref_decode(input logic [31:0] inst);
        expect_t     e;
        inst_class_e c;
        imm_fmt_e    fmt;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        w;
        logic [12:0] boff;
        logic        rd_use;
        logic        rs1_use;
        logic        rs2_use;
        e = '0;
        opc = inst[6:0];
        f3 = inst[14:12];
        f7 = inst[31:25];
        w = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
        c = CLS_UNKNOWN;
        if (inst[1:0] == 2'b11) begin
            case (opc)
                OPC_OP: begin
                    if (f7 == FUNCT7_MULDIV)
                        c = CLS_MULDIV;
                    else if (f7 == FUNCT7_BASE || (f7 == FUNCT7_ALT && f3 inside {3'd0, 3'd5}))
                        c = CLS_INT_MATH;
                end
                OPC_OP_32: begin
                    if (f7 == FUNCT7_MULDIV && (f3 == 3'd0 || f3[2]))
                        c = CLS_MULDIV;
                    else if ((f7 == FUNCT7_BASE && f3 inside {3'd0, 3'd1, 3'd5})
                             || (f7 == FUNCT7_ALT && f3 inside {3'd0, 3'd5}))
                        c = CLS_INT_MATH;
                end
                // rv64 shift amount is six bits wide
                OPC_OP_IMM: begin
                    if (!(f3 inside {3'd1, 3'd5}) || inst[31:26] == 6'd0
                        || (f3 == 3'd5 && inst[31:26] == 6'b010000))
                        c = CLS_IMM_MATH;
                end
                OPC_OP_IMM_32: begin
                    if (f3 == 3'd0 || (f3 == 3'd1 && f7 == FUNCT7_BASE)
                        || (f3 == 3'd5 && f7 inside {FUNCT7_BASE, FUNCT7_ALT}))
                        c = CLS_IMM_MATH;
                end
                OPC_LUI:    c = CLS_LUI;
                OPC_AUIPC:  c = CLS_AUIPC;
                OPC_JAL:    c = CLS_JAL;
                OPC_JALR:   c = (f3 == 3'd0) ? CLS_JALR : CLS_UNKNOWN;
                OPC_BRANCH: c = (f3 inside {3'd2, 3'd3}) ? CLS_UNKNOWN : CLS_BRANCH;
                OPC_LOAD:   c = (f3 != 3'd7) ? CLS_LOAD : CLS_UNKNOWN;
                OPC_STORE:  c = f3[2] ? CLS_UNKNOWN : CLS_STORE;
                OPC_SYSTEM: c = (f3 != 3'd0) ? CLS_CSR : CLS_UNKNOWN;
                default:    c = CLS_UNKNOWN;
            endcase
        end
        case (c)
            CLS_IMM_MATH:       fmt = (f3 inside {3'd1, 3'd5}) ? IMM_SHIFT : IMM_I;
            CLS_LOAD, CLS_JALR: fmt = IMM_I;
            CLS_STORE:          fmt = IMM_S;
            CLS_BRANCH:         fmt = IMM_B;
            CLS_LUI, CLS_AUIPC: fmt = IMM_U;
            CLS_JAL:            fmt = IMM_J;
            CLS_CSR:            fmt = IMM_CSR;
            default:            fmt = IMM_NONE;
        endcase
        boff = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        case (fmt)
            IMM_I:     e.dec.imm20 = {{8{inst[31]}}, inst[31:20]};
            IMM_S:     e.dec.imm20 = {{8{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:     e.dec.imm20 = {{7{boff[12]}}, boff};
            IMM_U:     e.dec.imm20 = inst[31:12];
            IMM_J:     e.dec.imm20 = {inst[19:12], inst[20], inst[30:21], 1'b0};
            IMM_SHIFT: e.dec.imm20 = {15'd0, inst[24:20]};
            IMM_CSR:   e.dec.imm20 = {3'd0, inst[31:15]};
            default:   e.dec.imm20 = '0;
        endcase
        e.dec.use_imm = (fmt != IMM_NONE);
        rd_use = !(c inside {CLS_BRANCH, CLS_STORE, CLS_UNKNOWN});
        rs1_use = !(c inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_CSR, CLS_UNKNOWN})
                  || (c == CLS_CSR && !inst[14]);
        rs2_use = c inside {CLS_INT_MATH, CLS_BRANCH, CLS_STORE, CLS_MULDIV};
        e.dec.regs.rd_wen = rd_use && (inst[11:7] != 5'd0);
        e.dec.regs.rs1_ren = rs1_use && (inst[19:15] != 5'd0);
        e.dec.regs.rs2_ren = rs2_use && (inst[24:20] != 5'd0);
        e.dec.regs.rd_idx = e.dec.regs.rd_wen ? inst[11:7] : 5'd0;
        e.dec.regs.rs1_idx = e.dec.regs.rs1_ren ? inst[19:15] : 5'd0;
        e.dec.regs.rs2_idx = e.dec.regs.rs2_ren ? inst[24:20] : 5'd0;
        e.dec.regs.is_mv = (c == CLS_IMM_MATH && opc == OPC_OP_IMM && f3 == 3'd0
                            && inst[31:20] == 12'd0)
                           || (c == CLS_INT_MATH && opc == OPC_OP && f3 == 3'd0
                               && f7 == FUNCT7_BASE && inst[24:20] == 5'd0);
        case (c)
            CLS_INT_MATH, CLS_IMM_MATH: begin
                e.dec.micop = w ? ALU_OP_W[f3] : ALU_OP[f3];
                if (f3 == 3'd0 && c == CLS_INT_MATH && inst[30])
                    e.dec.micop = w ? MOP_SUBW : MOP_SUB;
                if (f3 == 3'd5 && inst[30])
                    e.dec.micop = w ? MOP_SRAW : MOP_SRA;
            end
            CLS_LUI:    e.dec.micop = MOP_LUI;
            CLS_AUIPC:  e.dec.micop = MOP_AUIPC;
            CLS_JAL:    e.dec.micop = MOP_JAL;
            CLS_JALR:   e.dec.micop = MOP_JALR;
            CLS_BRANCH: e.dec.micop = BRU_OP[f3];
            CLS_MULDIV: e.dec.micop = w ? MDU_OP_W[f3] : MDU_OP[f3];
            default:    e.dec.micop = MOP_NONE;
        endcase
        if (c inside {CLS_LOAD, CLS_STORE})
            e.dec.disp_que = DQ_MEM_BLOCK;
        else if (c == CLS_UNKNOWN)
            e.dec.disp_que = DQ_UNKNOWN_BLOCK;
        else
            e.dec.disp_que = DQ_INT_BLOCK;
        if (c inside {CLS_INT_MATH, CLS_IMM_MATH, CLS_LUI})
            e.dec.issue_que = IQ_ALU;
        else if (c == CLS_MULDIV)
            e.dec.issue_que = IQ_MDU;
        else
            e.dec.issue_que = IQ_BRU;
        e.dec.is_store = (c == CLS_STORE);
        e.unk = (c == CLS_UNKNOWN);
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // inputs settle at the falling edge, so they are stable here
    always @(posedge i_clk) begin
        exp_valid = i_arst_n && i_valid;
        if (exp_valid) begin
            exp_q.push_back(ref_decode(i_inst));
        end
    end

    always @(negedge i_clk) begin
        expect_t e;
        if (!i_arst_n) begin
            compare_value("o_valid", o_valid, 1'b0);
            compare_value("o_unknown_inst", o_unknown_inst, 1'b0);
            compare_value("o_decinfo", o_decinfo, '0);
        end else begin
            compare_value("o_valid", o_valid, exp_valid);
            if (!o_valid) begin
                // record must hold on an idle cycle
                compare_value("o_decinfo", o_decinfo, last_out.dec);
                compare_value("o_unknown_inst", o_unknown_inst, last_out.unk);
            end else if (exp_q.size() == 0) begin
                num_errors++;
                $display("o_valid pulse at %0t with no instruction in flight", $time);
            end else begin
                e = exp_q.pop_front();
                compare_value("o_decinfo.regs.rd_wen", o_decinfo.regs.rd_wen, e.dec.regs.rd_wen);
                compare_value("o_decinfo.regs.rd_idx", o_decinfo.regs.rd_idx, e.dec.regs.rd_idx);
                compare_value("o_decinfo.regs.rs1_idx", o_decinfo.regs.rs1_idx,
                              e.dec.regs.rs1_idx);
                compare_value("o_decinfo.regs.rs2_idx", o_decinfo.regs.rs2_idx,
                              e.dec.regs.rs2_idx);
                compare_value("o_decinfo.regs.rs1_ren", o_decinfo.regs.rs1_ren,
                              e.dec.regs.rs1_ren);
                compare_value("o_decinfo.regs.rs2_ren", o_decinfo.regs.rs2_ren,
                              e.dec.regs.rs2_ren);
                compare_value("o_decinfo.regs.is_mv", o_decinfo.regs.is_mv, e.dec.regs.is_mv);
                compare_value("o_decinfo.imm20", o_decinfo.imm20, e.dec.imm20);
                compare_value("o_decinfo.use_imm", o_decinfo.use_imm, e.dec.use_imm);
                compare_value("o_decinfo.micop", o_decinfo.micop, e.dec.micop);
                compare_value("o_decinfo.disp_que", o_decinfo.disp_que, e.dec.disp_que);
                compare_value("o_decinfo.issue_que", o_decinfo.issue_que, e.dec.issue_que);
                compare_value("o_decinfo.is_store", o_decinfo.is_store, e.dec.is_store);
                compare_value("o_unknown_inst", o_unknown_inst, e.unk);
                last_out = e;
            end
        end
    end

    initial begin
        lfsr = 16'd21474;
        i_clk = 1'b0;
        i_arst_n = 1'b0;
        i_valid = 1'b0;
        i_inst = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            // about three cycles in four carry an instruction
            i_valid = (rand_bits(2) != 32'd0);
            i_inst = make_inst();
            @(negedge i_clk);
        end
        i_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        if (exp_q.size() != 0) begin
            num_errors++;
            $display("%0d decoded results never appeared on o_valid", exp_q.size());
        end
        $display("checks=%0d errors=%0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the instruction stream was fully decoded");
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
verilog/decode_pkg.sv
verilog/decode_ctrl.sv
verilog/imm_gen.sv
verilog/reg_field_unit.sv
verilog/micop_encoder.sv
verilog/decoder_top.sv
testbench/tb_decoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decoder
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
